/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_fetch_mem
SEED_ARGS ?= +verilator+seed+1
VFLAGS    ?= --binary --timing --assert -j 0
RUN_ARGS  ?= +verilator+error+limit+100
OBJ_DIR   ?= obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f build.f
	$(OBJ_DIR)/V$(TOP) $(SEED_ARGS) $(RUN_ARGS)

clean:
	rm -rf $(OBJ_DIR)

/* build.f */
fetch_pkg.sv
mem_bus_if.sv
icache.sv
lsu_port.sv
mem_arbiter.sv
main_mem.sv
fetch_mem_top.sv
tb_fetch_mem_assertions.sv
tb_fetch_mem.sv

/* fetch_mem_top.sv */
module fetch_mem_top (
    input  logic                            clk,
    input  logic                            rst,

    input  logic                            fetch_valid,
    output logic                            fetch_ready,
    input  logic [fetch_pkg::ADDR_WIDTH-1:0] fetch_addr,
    output logic                            fetch_rsp_valid,
    output logic [fetch_pkg::DATA_WIDTH-1:0] fetch_rdata,

    input  logic                            ls_valid,
    output logic                            ls_ready,
    input  logic                            ls_write,
    input  logic [fetch_pkg::ADDR_WIDTH-1:0] ls_addr,
    input  logic [fetch_pkg::DATA_WIDTH-1:0] ls_wdata,
    output logic                            ls_rsp_valid,
    output logic [fetch_pkg::DATA_WIDTH-1:0] ls_rdata
);

    mem_bus_if ic_bus ();
    mem_bus_if ls_bus ();
    mem_bus_if mem_bus ();

    icache i_icache (
        .clk             (clk),
        .rst             (rst),
        .fetch_valid     (fetch_valid),
        .fetch_ready     (fetch_ready),
        .fetch_addr      (fetch_addr),
        .fetch_rsp_valid (fetch_rsp_valid),
        .fetch_rdata     (fetch_rdata),
        .bus             (ic_bus)
    );

    lsu_port i_lsu_port (
        .clk          (clk),
        .rst          (rst),
        .ls_valid     (ls_valid),
        .ls_ready     (ls_ready),
        .ls_write     (ls_write),
        .ls_addr      (ls_addr),
        .ls_wdata     (ls_wdata),
        .ls_rsp_valid (ls_rsp_valid),
        .ls_rdata     (ls_rdata),
        .bus          (ls_bus)
    );

    mem_arbiter i_mem_arbiter (
        .clk (clk),
        .rst (rst),
        .m0  (ic_bus),
        .m1  (ls_bus),
        .s   (mem_bus)
    );

    main_mem i_main_mem (
        .clk (clk),
        .rst (rst),
        .bus (mem_bus)
    );

endmodule

/* fetch_pkg.sv */
package fetch_pkg;

    // Bus payload
    localparam int ADDR_WIDTH = 32;
    localparam int DATA_WIDTH = 32;

    // Instruction cache geometry, one word per line
    localparam int CACHE_LINES  = 16;
    localparam int OFFSET_WIDTH = 2;                      // Byte offset within a word
    localparam int INDEX_WIDTH  = $clog2(CACHE_LINES);
    localparam int TAG_WIDTH    = ADDR_WIDTH - INDEX_WIDTH - OFFSET_WIDTH;

    // Main memory
    localparam int MEM_WORDS       = 1024;
    localparam int MEM_INDEX_WIDTH = $clog2(MEM_WORDS);   // Word index, addr[11:2]
    localparam int MEM_LATENCY     = 3;                   // Accept to rsp_valid
    localparam int LAT_CNT_WIDTH   = $clog2(MEM_LATENCY + 1);

endpackage

/* icache.sv */
module icache (
    input  logic                            clk,
    input  logic                            rst,

    input  logic                            fetch_valid,
    output logic                            fetch_ready,
    input  logic [fetch_pkg::ADDR_WIDTH-1:0] fetch_addr,
    output logic                            fetch_rsp_valid,
    output logic [fetch_pkg::DATA_WIDTH-1:0] fetch_rdata,

    mem_bus_if.master                       bus
);

    typedef enum logic [1:0] {
        IDLE,
        LOOKUP,
        REFILL
    } state_t;

    state_t state;

    logic [fetch_pkg::ADDR_WIDTH-1:0]  addr_q;
    logic [fetch_pkg::TAG_WIDTH-1:0]   tag_q;
    logic [fetch_pkg::INDEX_WIDTH-1:0] index_q;

    logic [fetch_pkg::TAG_WIDTH-1:0]   tag_array  [fetch_pkg::CACHE_LINES];
    logic [fetch_pkg::DATA_WIDTH-1:0]  data_array [fetch_pkg::CACHE_LINES];
    logic [fetch_pkg::CACHE_LINES-1:0] valid_bits;

    logic req_pending;
    logic hit;
    logic fetch_accept;
    logic refill_done;

    assign tag_q   = addr_q[fetch_pkg::ADDR_WIDTH-1 -: fetch_pkg::TAG_WIDTH];
    assign index_q = addr_q[fetch_pkg::OFFSET_WIDTH +: fetch_pkg::INDEX_WIDTH];

    assign fetch_ready  = (state == IDLE);
    assign fetch_accept = fetch_valid && fetch_ready;
    assign refill_done  = (state == REFILL) && bus.rsp_valid;

    assign hit = valid_bits[index_q] && (tag_array[index_q] == tag_q);

    // Refill is always a word-aligned read
    assign bus.req_valid = req_pending;
    assign bus.write     = 1'b0;
    assign bus.addr      = {addr_q[fetch_pkg::ADDR_WIDTH-1:fetch_pkg::OFFSET_WIDTH],
                            {fetch_pkg::OFFSET_WIDTH{1'b0}}};
    assign bus.wdata     = '0;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state           <= IDLE;
            req_pending     <= 1'b0;
            fetch_rsp_valid <= 1'b0;
        end else begin
            fetch_rsp_valid <= 1'b0;
            case (state)
                IDLE: begin
                    if (fetch_accept) begin
                        state <= LOOKUP;
                    end
                end
                LOOKUP: begin
                    if (hit) begin
                        fetch_rsp_valid <= 1'b1;
                        state           <= IDLE;
                    end else begin
                        req_pending <= 1'b1;        // Miss, go to memory
                        state       <= REFILL;
                    end
                end
                REFILL: begin
                    if (bus.req_valid && bus.req_ready) begin
                        req_pending <= 1'b0;
                    end
                    if (bus.rsp_valid) begin
                        fetch_rsp_valid <= 1'b1;
                        state           <= IDLE;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid_bits <= '0;
        end else if (refill_done) begin
            valid_bits[index_q] <= 1'b1;
        end
    end

    // Address register, line arrays and read data
    always_ff @(posedge clk) begin
        if (fetch_accept) begin
            addr_q <= fetch_addr;
        end
        if (state == LOOKUP && hit) begin
            fetch_rdata <= data_array[index_q];
        end
        if (refill_done) begin
            tag_array[index_q]  <= tag_q;
            data_array[index_q] <= bus.rdata;
            fetch_rdata         <= bus.rdata;   // Forward refilled word
        end
    end

endmodule

/* lsu_port.sv */
module lsu_port (
    input  logic                            clk,
    input  logic                            rst,

    input  logic                            ls_valid,
    output logic                            ls_ready,
    input  logic                            ls_write,
    input  logic [fetch_pkg::ADDR_WIDTH-1:0] ls_addr,
    input  logic [fetch_pkg::DATA_WIDTH-1:0] ls_wdata,
    output logic                            ls_rsp_valid,
    output logic [fetch_pkg::DATA_WIDTH-1:0] ls_rdata,

    mem_bus_if.master                       bus
);

    logic full;          // Request held until its response returns
    logic req_pending;   // Request not yet taken by the bus
    logic write_q;
    logic ls_accept;

    assign ls_ready  = !full;
    assign ls_accept = ls_valid && ls_ready;

    assign bus.req_valid = req_pending;
    assign bus.write     = write_q;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            full         <= 1'b0;
            req_pending  <= 1'b0;
            ls_rsp_valid <= 1'b0;
        end else begin
            ls_rsp_valid <= bus.rsp_valid;
            if (ls_accept) begin
                full        <= 1'b1;
                req_pending <= 1'b1;
            end else if (bus.req_valid && bus.req_ready) begin
                req_pending <= 1'b0;
            end else if (bus.rsp_valid) begin
                full <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ls_accept) begin
            write_q   <= ls_write;
            bus.addr  <= ls_addr;
            bus.wdata <= ls_wdata;
        end
        if (bus.rsp_valid) begin
            ls_rdata <= write_q ? '0 : bus.rdata;   // Store gets a plain ack
        end
    end

endmodule

/* main_mem.sv */
module main_mem (
    input  logic     clk,
    input  logic     rst,

    mem_bus_if.slave bus
);

    logic [fetch_pkg::DATA_WIDTH-1:0]      mem [fetch_pkg::MEM_WORDS];
    logic [fetch_pkg::MEM_INDEX_WIDTH-1:0] req_index;
    logic [fetch_pkg::MEM_INDEX_WIDTH-1:0] index_q;
    logic [fetch_pkg::LAT_CNT_WIDTH-1:0]   cnt;
    logic                                  busy;
    logic                                  accept;

    assign req_index     = bus.addr[fetch_pkg::OFFSET_WIDTH +: fetch_pkg::MEM_INDEX_WIDTH];
    assign bus.req_ready = !busy;
    assign accept        = bus.req_valid && bus.req_ready;

    // Latency counter, rsp_valid is registered on the last count
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy          <= 1'b0;
            cnt           <= '0;
            bus.rsp_valid <= 1'b0;
        end else begin
            bus.rsp_valid <= 1'b0;
            if (accept) begin
                busy <= 1'b1;
                cnt  <= fetch_pkg::LAT_CNT_WIDTH'(fetch_pkg::MEM_LATENCY - 1);
            end else if (busy) begin
                cnt <= cnt - 1'b1;
                if (cnt == 1) begin
                    busy          <= 1'b0;
                    bus.rsp_valid <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            index_q <= req_index;
            if (bus.write) begin
                mem[req_index] <= bus.wdata;   // Store lands at acceptance
            end
        end
        if (busy && cnt == 1) begin
            bus.rdata <= mem[index_q];
        end
    end

endmodule

/* mem_arbiter.sv */
module mem_arbiter (
    input  logic      clk,
    input  logic      rst,

    mem_bus_if.slave  m0,   // Instruction side
    mem_bus_if.slave  m1,   // Load/store side
    mem_bus_if.master s
);

    logic busy;          // Transaction outstanding at the memory
    logic owner;         // 0 = m0, 1 = m1
    logic last_served;
    logic grant_m0;
    logic grant_m1;

    // Locked to the owner while busy, round robin otherwise
    always_comb begin
        if (busy) begin
            grant_m0 = !owner;
            grant_m1 = owner;
        end else begin
            grant_m0 = m0.req_valid && (!m1.req_valid || last_served);
            grant_m1 = m1.req_valid && (!m0.req_valid || !last_served);
        end
    end

    assign s.req_valid = !busy && ((grant_m0 && m0.req_valid) || (grant_m1 && m1.req_valid));
    assign s.write     = grant_m1 ? m1.write : m0.write;
    assign s.addr      = grant_m1 ? m1.addr  : m0.addr;
    assign s.wdata     = grant_m1 ? m1.wdata : m0.wdata;

    assign m0.req_ready = !busy && grant_m0 && s.req_ready;
    assign m1.req_ready = !busy && grant_m1 && s.req_ready;

    // Response goes back to the owner alone
    assign m0.rsp_valid = busy && !owner && s.rsp_valid;
    assign m1.rsp_valid = busy && owner && s.rsp_valid;
    assign m0.rdata     = owner ? '0 : s.rdata;
    assign m1.rdata     = owner ? s.rdata : '0;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy        <= 1'b0;
            owner       <= 1'b0;
            last_served <= 1'b0;
        end else begin
            if (s.req_valid && s.req_ready) begin
                busy        <= 1'b1;
                owner       <= grant_m1;
                last_served <= grant_m1;
            end else if (busy && s.rsp_valid) begin
                busy <= 1'b0;
            end
        end
    end

endmodule

/* mem_bus_if.sv */
interface mem_bus_if;

    logic                            req_valid;
    logic                            req_ready;
    logic                            write;       // 1 = store, 0 = load
    logic [fetch_pkg::ADDR_WIDTH-1:0] addr;        // Byte address
    logic [fetch_pkg::DATA_WIDTH-1:0] wdata;

    logic                            rsp_valid;   // One-cycle pulse, no ready
    logic [fetch_pkg::DATA_WIDTH-1:0] rdata;

    modport master (
        output req_valid,
        input  req_ready,
        output write,
        output addr,
        output wdata,
        input  rsp_valid,
        input  rdata
    );

    modport slave (
        input  req_valid,
        output req_ready,
        input  write,
        input  addr,
        input  wdata,
        output rsp_valid,
        output rdata
    );

endinterface

/* tb_fetch_mem.sv */
module tb_fetch_mem;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int TIMEOUT     = 200;
    localparam int HIT_CYCLES  = 2;
    localparam int MISS_CYCLES = 2 + fetch_pkg::MEM_LATENCY + 1;   // Lookup, request, memory, return

    logic                             clk = 1'b0;
    logic                             rst;
    logic                             fetch_valid;
    logic                             fetch_ready;
    logic [fetch_pkg::ADDR_WIDTH-1:0] fetch_addr;
    logic                             fetch_rsp_valid;
    logic [fetch_pkg::DATA_WIDTH-1:0] fetch_rdata;
    logic                             ls_valid;
    logic                             ls_ready;
    logic                             ls_write;
    logic [fetch_pkg::ADDR_WIDTH-1:0] ls_addr;
    logic [fetch_pkg::DATA_WIDTH-1:0] ls_wdata;
    logic                             ls_rsp_valid;
    logic [fetch_pkg::DATA_WIDTH-1:0] ls_rdata;

    logic [fetch_pkg::DATA_WIDTH-1:0] shadow [fetch_pkg::MEM_WORDS];   // Mirror of every store
    logic [fetch_pkg::DATA_WIDTH-1:0] fetch_exp [$];
    logic [fetch_pkg::DATA_WIDTH-1:0] ls_exp [$];
    bit                               ls_chk [$];                      // Loads carry data
    logic [fetch_pkg::ADDR_WIDTH-1:0] data_addrs [$];
    string                            test_name;
    integer                           seed;

    fetch_mem_top i_fetch_mem_top (
        .clk             (clk),
        .rst             (rst),
        .fetch_valid     (fetch_valid),
        .fetch_ready     (fetch_ready),
        .fetch_addr      (fetch_addr),
        .fetch_rsp_valid (fetch_rsp_valid),
        .fetch_rdata     (fetch_rdata),
        .ls_valid        (ls_valid),
        .ls_ready        (ls_ready),
        .ls_write        (ls_write),
        .ls_addr         (ls_addr),
        .ls_wdata        (ls_wdata),
        .ls_rsp_valid    (ls_rsp_valid),
        .ls_rdata        (ls_rdata)
    );

    always #2 clk = ~clk;

    task automatic fail_run(input string what);
        $display("%s: %s", test_name, what);
        $display("test failed");
        $fatal(1);
    endtask

    task automatic fail_value(input string what, input logic [31:0] expected,
                              input logic [31:0] actual);
        $display("[FAIL] %s: %s expected 0x%0h actual 0x%0h", test_name, what, expected, actual);
        $display("test failed");
        $fatal(1);
    endtask

    // Memory ignores address bits above the word index
    function automatic logic [fetch_pkg::DATA_WIDTH-1:0] expected_word(
        input logic [fetch_pkg::ADDR_WIDTH-1:0] addr);
        return shadow[addr[fetch_pkg::OFFSET_WIDTH +: fetch_pkg::MEM_INDEX_WIDTH]];
    endfunction

    task automatic ls_access(input bit wr, input logic [31:0] addr, input logic [31:0] wdata);
        int waited;
        waited = 0;
        while (!ls_ready) begin
            @(negedge clk);
            waited++;
            assert (waited < TIMEOUT) else fail_run("ls_ready stayed low");
        end
        if (wr) begin
            shadow[addr[fetch_pkg::OFFSET_WIDTH +: fetch_pkg::MEM_INDEX_WIDTH]] = wdata;
        end
        ls_exp.push_back(expected_word(addr));
        ls_chk.push_back(!wr);
        ls_valid = 1'b1;
        ls_write = wr;
        ls_addr  = addr;
        ls_wdata = wdata;
        @(negedge clk);
        ls_valid = 1'b0;
        waited   = 0;
        while (!ls_rsp_valid) begin
            @(negedge clk);
            waited++;
            assert (waited < TIMEOUT) else fail_run("no load/store response");
        end
    endtask

    // Cycles counted from the accepting edge to the response
    task automatic fetch_word(input logic [31:0] addr, input logic [31:0] expected,
                              output int cycles);
        int waited;
        waited = 0;
        while (!fetch_ready) begin
            @(negedge clk);
            waited++;
            assert (waited < TIMEOUT) else fail_run("fetch_ready stayed low");
        end
        fetch_exp.push_back(expected);
        fetch_valid = 1'b1;
        fetch_addr  = addr;
        @(negedge clk);
        fetch_valid = 1'b0;
        cycles      = 1;
        while (!fetch_rsp_valid) begin
            @(negedge clk);
            cycles++;
            assert (cycles < TIMEOUT) else fail_run("no fetch response");
        end
    endtask

    always @(negedge clk) begin : compare_rsp
        logic [31:0] expected;
        bit          chk;
        if (!rst) begin
            assert (i_fetch_mem_top.i_mem_arbiter.i_arb_assertions.error_count == 0)
                else fail_run("a bus protocol assertion fired");
            if (fetch_rsp_valid) begin
                assert (fetch_exp.size() > 0) else fail_run("fetch response with none pending");
                expected = fetch_exp.pop_front();
                assert (fetch_rdata === expected) else fail_value("fetch data", expected, fetch_rdata);
            end
            if (ls_rsp_valid) begin
                assert (ls_exp.size() > 0) else fail_run("load/store response with none pending");
                expected = ls_exp.pop_front();
                chk      = ls_chk.pop_front();
                if (chk) begin
                    assert (ls_rdata === expected) else fail_value("load data", expected, ls_rdata);
                end
            end
        end
    end

    initial begin : run
        int          cycles;
        logic [31:0] addr;
        logic [31:0] old_word;
        logic [31:0] fetch_list [$];
        logic [31:0] load_list [$];
        seed        = 32'h3a65;
        rst         = 1'b1;
        fetch_valid = 1'b0;
        fetch_addr  = '0;
        ls_valid    = 1'b0;
        ls_write    = 1'b0;
        ls_addr     = '0;
        ls_wdata    = '0;
        test_name   = "reset";
        repeat (2) @(negedge clk);
        rst = 1'b0;
        repeat (8) begin
            @(negedge clk);
            assert (fetch_ready && ls_ready) else fail_run("ready low while idle after reset");
            assert (!fetch_rsp_valid && !ls_rsp_valid) else fail_run("response while idle");
        end

        test_name = "store_load";
        repeat (32) begin
            addr = 32'h800 + ($random(seed) & 32'h7fc);   // Data region
            data_addrs.push_back(addr);
            ls_access(1'b1, addr, $random(seed));
        end
        foreach (data_addrs[i]) ls_access(1'b0, data_addrs[i], '0);

        test_name = "write_fetch";
        for (int i = 0; i < 16; i++) ls_access(1'b1, i * 4, $random(seed));
        fetch_word(32'h010, expected_word(32'h010), cycles);
        assert (cycles == MISS_CYCLES) else fail_value("miss cycles", MISS_CYCLES, cycles);
        fetch_word(32'h010, expected_word(32'h010), cycles);
        assert (cycles == HIT_CYCLES) else fail_value("hit cycles", HIT_CYCLES, cycles);
        for (int i = 0; i < 16; i++) fetch_word(i * 4, expected_word(i * 4), cycles);

        test_name = "conflict";
        ls_access(1'b1, 32'h104, $random(seed));   // Both map to line 1
        ls_access(1'b1, 32'h144, $random(seed));
        for (int i = 0; i < 6; i++) begin
            addr = (i % 2 == 0) ? 32'h104 : 32'h144;
            fetch_word(addr, expected_word(addr), cycles);
            if (i > 0) begin
                assert (cycles > HIT_CYCLES) else fail_value("evicted fetch cycles", MISS_CYCLES,
                                                             cycles);
            end
        end

        test_name = "stale_line";
        old_word = expected_word(32'h020);
        ls_access(1'b1, 32'h020, ~old_word);
        fetch_word(32'h020, old_word, cycles);   // Cache keeps the word it holds

        test_name = "contention";
        for (int i = 0; i < 32; i++) ls_access(1'b1, 32'h200 + i * 4, $random(seed));
        repeat (24) begin
            fetch_list.push_back(32'h200 + (($random(seed) & 31) << 2));
            load_list.push_back(data_addrs[$random(seed) & 31]);
        end
        fork
            foreach (fetch_list[i]) fetch_word(fetch_list[i], expected_word(fetch_list[i]), cycles);
            foreach (load_list[i]) ls_access(1'b0, load_list[i], '0);
        join

        repeat (2) @(negedge clk);
        if (fetch_exp.size() == 0 && ls_exp.size() == 0 &&
            i_fetch_mem_top.i_mem_arbiter.i_arb_assertions.error_count == 0) begin
            $display("test passed");
            $finish;
        end else begin
            fail_run("responses missing or assertion errors at end of run");
        end
    end

endmodule

/* tb_fetch_mem_assertions.sv */
module tb_fetch_mem_assertions (
    input logic                             clk,
    input logic                             rst,
    input logic                             grant_m0,
    input logic                             grant_m1,
    input logic                             m0_req_valid,
    input logic                             m0_req_ready,
    input logic [fetch_pkg::ADDR_WIDTH-1:0] m0_addr,
    input logic                             m1_req_valid,
    input logic                             m1_req_ready,
    input logic [fetch_pkg::ADDR_WIDTH-1:0] m1_addr,
    input logic                             s_req_valid,
    input logic                             s_req_ready,
    input logic                             s_rsp_valid
);
    timeunit 1ns;
    timeprecision 100ps;

    int   error_count = 0;   // Read by the testbench top
    logic s_accept;

    assign s_accept = s_req_valid && s_req_ready;

    grant_exclusive: assert property (@(posedge clk) disable iff (rst)
        !(grant_m0 && grant_m1))
        else begin
            error_count++;
            $error("both arbiter grants high");
        end

    rsp_after_accept: assert property (@(posedge clk) disable iff (rst)
        s_accept |-> ##(fetch_pkg::MEM_LATENCY) s_rsp_valid)
        else begin
            error_count++;
            $error("no memory response MEM_LATENCY cycles after acceptance");
        end

    rsp_not_early: assert property (@(posedge clk) disable iff (rst)
        s_rsp_valid |-> $past(s_accept, fetch_pkg::MEM_LATENCY))
        else begin
            error_count++;
            $error("memory response without acceptance MEM_LATENCY cycles before");
        end

    m0_hold: assert property (@(posedge clk) disable iff (rst)
        (m0_req_valid && !m0_req_ready) |=> (m0_req_valid && $stable(m0_addr)))
        else begin
            error_count++;
            $error("instruction side dropped or changed a waiting request");
        end

    m1_hold: assert property (@(posedge clk) disable iff (rst)
        (m1_req_valid && !m1_req_ready) |=> (m1_req_valid && $stable(m1_addr)))
        else begin
            error_count++;
            $error("load/store side dropped or changed a waiting request");
        end

endmodule

bind mem_arbiter tb_fetch_mem_assertions i_arb_assertions (
    .clk          (clk),
    .rst          (rst),
    .grant_m0     (grant_m0),
    .grant_m1     (grant_m1),
    .m0_req_valid (m0.req_valid),
    .m0_req_ready (m0.req_ready),
    .m0_addr      (m0.addr),
    .m1_req_valid (m1.req_valid),
    .m1_req_ready (m1.req_ready),
    .m1_addr      (m1.addr),
    .s_req_valid  (s.req_valid),
    .s_req_ready  (s.req_ready),
    .s_rsp_valid  (s.rsp_valid)
);
